/* Bender.yml */
package:
  name: dac_prescale

sources:
  # packages first, then the interface and the modules bottom up
  - hw/dac_fmt_pkg.sv
  - hw/cfg_pkg.sv
  - hw/coeff_wr_if.sv
  - hw/prescale_cfg_slave.sv
  - hw/prescale_lane.sv
  - hw/dac_prescaler.sv
  - hw/dac_prescale_top.sv

  - target: test
    files:
      - tb/tb_dac_prescale.sv

/* all.f */
hw/dac_fmt_pkg.sv
hw/cfg_pkg.sv
hw/coeff_wr_if.sv
hw/prescale_cfg_slave.sv
hw/prescale_lane.sv
hw/dac_prescaler.sv
hw/dac_prescale_top.sv
tb/tb_dac_prescale.sv

/* hw/cfg_pkg.sv */
package cfg_pkg;

  // wide enough to address up to eight channels
  localparam int chan_idx_width = 3;

  typedef logic [chan_idx_width-1:0] chan_idx_t;

  // states of the four-phase configuration slave
  //   st_idle     waiting for the master to raise req
  //   st_write    request captured, coefficient write issued this cycle
  //   st_ack      ack raised for the first time
  //   st_release  ack held until the master drops req
  typedef enum logic [1:0] {
    st_idle,
    st_write,
    st_ack,
    st_release
  } cfg_state_t;

endpackage

/* hw/coeff_wr_if.sv */
`timescale 1ns/1ps

// a single coefficient write is valid for the one cycle in which wr is high
interface coeff_wr_if
  import dac_fmt_pkg::*, cfg_pkg::*;
();

  logic wr;
  chan_idx_t channel;
  scale_t scale;
  offset_t offset;

  modport source (
    output wr,
    output channel,
    output scale,
    output offset
  );

  modport sink (
    input wr,
    input channel,
    input scale,
    input offset
  );

endinterface

/* hw/dac_fmt_pkg.sv */
package dac_fmt_pkg;

  // samples are two's complement and full scale spans the whole word
  localparam int sample_width = 16;

  // scale is Q2.16, so the usable range is -2.0 up to just under 2.0
  localparam int scale_width = 18;
  localparam int scale_frac_bits = 16;

  // offset is Q2.12 in units of full scale
  localparam int offset_width = 14;
  localparam int offset_frac_bits = 12;

  // one offset LSB is this many sample LSBs, expressed as a left shift
  localparam int offset_shift = sample_width - offset_frac_bits;

  // full product of a sample and a scale factor with no bits dropped
  localparam int product_width = sample_width + scale_width;

  // register stages between a sample entering a lane and leaving it
  localparam int lane_latency = 3;

  typedef logic signed [sample_width-1:0] sample_t;
  typedef logic signed [scale_width-1:0] scale_t;
  typedef logic signed [offset_width-1:0] offset_t;
  typedef logic signed [product_width-1:0] product_t;

  // unity gain is loaded into every channel at reset
  localparam scale_t scale_one = scale_t'(18'h10000);

endpackage

/* hw/dac_prescale_top.sv */
`timescale 1ns/1ps

module dac_prescale_top
  import dac_fmt_pkg::*;
  import cfg_pkg::*;
#(
  parameter int channels = 2,
  parameter int parallel_samples = 4
) (
  input logic clk,
  input logic reset,

  // sample stream in with lane 0 in the low bits of each channel word
  input logic [channels-1:0][parallel_samples*sample_width-1:0] in_data,
  input logic [channels-1:0] in_valid,

  // sample stream out three cycles behind the input
  output logic [channels-1:0][parallel_samples*sample_width-1:0] out_data,
  output logic [channels-1:0] out_valid,

  // four-phase configuration port
  input logic cfg_req,
  input chan_idx_t cfg_channel,
  input scale_t cfg_scale,
  input offset_t cfg_offset,
  output logic cfg_ack
);

  coeff_wr_if u_coeff_wr ();

  prescale_cfg_slave #(
    .channels(channels)
  ) u_cfg_slave (
    .clk(clk),
    .reset(reset),
    .cfg_req(cfg_req),
    .cfg_channel(cfg_channel),
    .cfg_scale(cfg_scale),
    .cfg_offset(cfg_offset),
    .cfg_ack(cfg_ack),
    .coeff(u_coeff_wr.source)
  );

  dac_prescaler #(
    .channels(channels),
    .parallel_samples(parallel_samples)
  ) u_prescaler (
    .clk(clk),
    .reset(reset),
    .in_data(in_data),
    .in_valid(in_valid),
    .coeff(u_coeff_wr.sink),
    .out_data(out_data),
    .out_valid(out_valid)
  );

endmodule

/* hw/dac_prescaler.sv */
`timescale 1ns/1ps

module dac_prescaler
  import dac_fmt_pkg::*;
  import cfg_pkg::*;
#(
  parameter int channels = 2,
  parameter int parallel_samples = 4
) (
  input logic clk,
  input logic reset,
  input logic [channels-1:0][parallel_samples*sample_width-1:0] in_data,
  input logic [channels-1:0] in_valid,
  coeff_wr_if.sink coeff,
  output logic [channels-1:0][parallel_samples*sample_width-1:0] out_data,
  output logic [channels-1:0] out_valid
);

  // one scale and one offset per channel are shared by all of its lanes
  scale_t scale_q [channels];
  offset_t offset_q [channels];

  // valid follows the data through the same number of stages
  logic [lane_latency-1:0] valid_pipe [channels];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int c = 0; c < channels; c++) begin
        scale_q[c] <= scale_one;
        offset_q[c] <= '0;
      end
    end else if (coeff.wr) begin
      for (int c = 0; c < channels; c++) begin
        if (coeff.channel == chan_idx_t'(c)) begin
          scale_q[c] <= coeff.scale;
          offset_q[c] <= coeff.offset;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int c = 0; c < channels; c++) begin
        valid_pipe[c] <= '0;
      end
    end else begin
      for (int c = 0; c < channels; c++) begin
        valid_pipe[c] <= {valid_pipe[c][lane_latency-2:0], in_valid[c]};
      end
    end
  end

  always_comb begin
    for (int c = 0; c < channels; c++) begin
      out_valid[c] = valid_pipe[c][lane_latency-1];
    end
  end

  // lanes run every cycle whether valid is high or not
  for (genvar c = 0; c < channels; c++) begin : g_chan
    for (genvar p = 0; p < parallel_samples; p++) begin : g_lane
      sample_t lane_sample;

      prescale_lane u_lane (
        .clk(clk),
        .reset(reset),
        .in_sample(sample_t'(in_data[c][p*sample_width +: sample_width])),
        .scale(scale_q[c]),
        .offset(offset_q[c]),
        .out_sample(lane_sample)
      );

      assign out_data[c][p*sample_width +: sample_width] = lane_sample;
    end
  end

endmodule

/* hw/prescale_cfg_slave.sv */
`timescale 1ns/1ps

module prescale_cfg_slave
  import dac_fmt_pkg::*;
  import cfg_pkg::*;
#(
  parameter int channels = 2
) (
  input logic clk,
  input logic reset,
  input logic cfg_req,
  input chan_idx_t cfg_channel,
  input scale_t cfg_scale,
  input offset_t cfg_offset,
  output logic cfg_ack,
  coeff_wr_if.source coeff
);

  cfg_state_t state;
  cfg_state_t state_next;

  // request fields held from the capture edge until the write goes out
  chan_idx_t channel_q;
  scale_t scale_q;
  offset_t offset_q;

  logic in_range;

  always_comb begin
    state_next = state;
    case (state)
      st_idle: begin
        if (cfg_req) begin
          state_next = st_write;
        end
      end
      st_write: begin
        state_next = st_ack;
      end
      st_ack: begin
        state_next = st_release;
      end
      st_release: begin
        // ack drops on the edge after req is seen low
        if (!cfg_req) begin
          state_next = st_idle;
        end
      end
      default: begin
        state_next = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

  // the master keeps the fields stable while req is high, so capture once
  always_ff @(posedge clk) begin
    if (state == st_idle && cfg_req) begin
      channel_q <= cfg_channel;
      scale_q <= cfg_scale;
      offset_q <= cfg_offset;
    end
  end

  // out of range requests still go through the handshake but never write
  assign in_range = int'(channel_q) < channels;

  assign coeff.wr = (state == st_write) && in_range;
  assign coeff.channel = channel_q;
  assign coeff.scale = scale_q;
  assign coeff.offset = offset_q;

  assign cfg_ack = (state == st_ack) || (state == st_release);

endmodule

/* hw/prescale_lane.sv */
`timescale 1ns/1ps

module prescale_lane
  import dac_fmt_pkg::*;
(
  input logic clk,
  input logic reset,
  input sample_t in_sample,
  input scale_t scale,
  input offset_t offset,
  output sample_t out_sample
);

  // the product after the fractional shift needs product_width - scale_frac_bits
  // bits and one more keeps the offset add from wrapping
  localparam int sum_width = product_width - scale_frac_bits + 1;

  localparam logic signed [sum_width-1:0] sat_max = (1 <<< (sample_width - 1)) - 1;
  localparam logic signed [sum_width-1:0] sat_min = -(1 <<< (sample_width - 1));

  product_t product_q;
  logic signed [sum_width-1:0] floored;
  logic signed [sum_width-1:0] offset_ext;
  logic signed [sum_width-1:0] sum_q;

  // arithmetic shift right rounds toward minus infinity, which is the floor
  assign floored = sum_width'(product_q >>> scale_frac_bits);

  // bring the offset onto the sample LSB grid
  assign offset_ext = sum_width'(offset) <<< offset_shift;

  always_ff @(posedge clk) begin
    if (reset) begin
      product_q <= '0;
      sum_q <= '0;
      out_sample <= '0;
    end else begin
      // stage 1
      product_q <= in_sample * scale;

      // stage 2
      sum_q <= floored + offset_ext;

      // stage 3 clamps to the sample range
      if (sum_q > sat_max) begin
        out_sample <= sample_t'(sat_max);
      end else if (sum_q < sat_min) begin
        out_sample <= sample_t'(sat_min);
      end else begin
        out_sample <= sample_t'(sum_q);
      end
    end
  end

endmodule

/* tb/tb_dac_prescale.sv */
`timescale 1ns/1ps

module tb_dac_prescale
  import dac_fmt_pkg::*, cfg_pkg::*;
();

  localparam int channels = 2;
  localparam int parallel_samples = 4;
  localparam int word_width = parallel_samples * sample_width;
  localparam int num_rows = 8;
  localparam int ack_wait_limit = 10;

  // each table row is an optional coefficient write followed by a burst of beats
  typedef struct packed {
    chan_idx_t channel;
    logic do_write;
    scale_t scale;
    offset_t offset;
    logic [7:0] beats;
    logic alternate;
  } row_t;

  typedef struct packed {
    logic [word_width-1:0] data;
    logic [31:0] due;
  } exp_entry_t;

  localparam row_t stim_table [num_rows] = '{
    // unity pass-through after reset with continuous and then gapped valid
    '{3'd0, 1'b0, 18'h10000, 14'h0000, 8'd8, 1'b0},
    '{3'd0, 1'b0, 18'h10000, 14'h0000, 8'd6, 1'b1},
    // channel 0 gets 0.5 and a positive offset while channel 1 stays at unity
    '{3'd0, 1'b1, 18'h08000, 14'h0100, 8'd8, 1'b0},
    // -0.75 with offset -100 exercises floor on negative products
    '{3'd0, 1'b1, 18'h34000, 14'h3f9c, 8'd8, 1'b1},
    // just under 2.0 on channel 1 drives large samples into saturation
    '{3'd1, 1'b1, 18'h1ffff, 14'h0000, 8'd6, 1'b0},
    // -2.0 with offset -0.5 full scale pins positive samples to the lower rail
    '{3'd0, 1'b1, 18'h20000, 14'h3800, 8'd6, 1'b1},
    // channel 5 does not exist so nothing may change
    '{3'd5, 1'b1, 18'h00000, 14'h0000, 8'd6, 1'b0},
    '{3'd1, 1'b1, 18'h10000, 14'h0000, 8'd4, 1'b1}
  };

  logic clk;
  logic reset;
  logic [channels-1:0][word_width-1:0] in_data;
  logic [channels-1:0] in_valid;
  logic [channels-1:0][word_width-1:0] out_data;
  logic [channels-1:0] out_valid;
  logic cfg_req;
  chan_idx_t cfg_channel;
  scale_t cfg_scale;
  offset_t cfg_offset;
  logic cfg_ack;

  logic [15:0] lfsr;
  int cycle_count;
  int timeout_limit;
  scale_t model_scale [channels];
  offset_t model_offset [channels];
  exp_entry_t exp_q [channels][$];

  dac_prescale_top #(
    .channels(channels),
    .parallel_samples(parallel_samples)
  ) u_dut (
    .clk(clk),
    .reset(reset),
    .in_data(in_data),
    .in_valid(in_valid),
    .out_data(out_data),
    .out_valid(out_valid),
    .cfg_req(cfg_req),
    .cfg_channel(cfg_channel),
    .cfg_scale(cfg_scale),
    .cfg_offset(cfg_offset),
    .cfg_ack(cfg_ack)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic stop_on_failure(input string reason);
    $display("%s", reason);
    $display("Some tests failed");
    $fatal(1, "simulation stopped after a failure");
  endtask

  task automatic compare_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
    if (actual !== expected) begin
      stop_on_failure($sformatf("ERR %s: got 0x%h, expected 0x%h", name, actual, expected));
    end
  endtask

  // Galois LFSR with taps 16, 14, 13 and 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 16'hb400;
    end
    return state >> 1;
  endfunction

  task automatic draw_random_sample(output sample_t sample);
    for (int i = 0; i < sample_width; i++) begin
      sample = {sample[sample_width-2:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  // floor the product onto the sample grid, add 16 sample LSBs per offset LSB and clamp
  function automatic sample_t expected_sample(input sample_t s, input scale_t sc,
                                              input offset_t off);
    longint value;
    value = ((longint'(s) * longint'(sc)) >>> 16) + longint'(off) * 16;
    if (value > 32767) begin
      value = 32767;
    end else if (value < -32768) begin
      value = -32768;
    end
    return sample_t'(value);
  endfunction

  task automatic write_coeff(input chan_idx_t ch, input scale_t sc, input offset_t off);
    int waited;
    @(negedge clk);
    compare_value("cfg_ack", cfg_ack, 64'd0);
    @(posedge clk);
    cfg_channel <= ch;
    cfg_scale <= sc;
    cfg_offset <= off;
    cfg_req <= 1'b1;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!cfg_ack && waited < ack_wait_limit);
    if (!cfg_ack) begin
      stop_on_failure("cfg_ack never rose after cfg_req was raised");
    end
    if (int'(ch) < channels) begin
      model_scale[ch] = sc;
      model_offset[ch] = off;
    end
    // ack has to stay up for as long as req is held
    @(negedge clk);
    compare_value("cfg_ack", cfg_ack, 64'd1);
    @(posedge clk);
    cfg_req <= 1'b0;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (cfg_ack && waited < ack_wait_limit);
    if (cfg_ack) begin
      stop_on_failure("cfg_ack never fell after cfg_req was dropped");
    end
  endtask

  task automatic stream_beats(input int beats, input logic alternate);
    int sent;
    logic phase;
    sample_t s;
    logic [word_width-1:0] word;
    logic [word_width-1:0] exp_word;
    sent = 0;
    phase = 1'b0;
    while (sent < beats) begin
      @(posedge clk);
      if (!alternate || !phase) begin
        for (int c = 0; c < channels; c++) begin
          for (int p = 0; p < parallel_samples; p++) begin
            draw_random_sample(s);
            word[p*sample_width +: sample_width] = s;
            exp_word[p*sample_width +: sample_width] =
              expected_sample(s, model_scale[c], model_offset[c]);
          end
          in_data[c] <= word;
          // sampled by the DUT on the next edge and out three edges after that
          exp_q[c].push_back('{exp_word, 32'(cycle_count + lane_latency + 1)});
        end
        in_valid <= '1;
        sent++;
      end else begin
        in_valid <= '0;
      end
      phase = ~phase;
    end
    @(posedge clk);
    in_valid <= '0;
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_limit) begin
      stop_on_failure("timeout, the run did not finish within the cycle limit");
    end
  end

  always @(negedge clk) begin : monitor
    exp_entry_t entry;
    if (!reset) begin
      for (int c = 0; c < channels; c++) begin
        if (out_valid[c]) begin
          if (exp_q[c].size() == 0) begin
            stop_on_failure($sformatf("out_valid high on channel %0d with no beat sent", c));
          end else begin
            entry = exp_q[c].pop_front();
            compare_value($sformatf("out_data[%0d]", c), out_data[c], entry.data);
            compare_value($sformatf("out_valid[%0d] cycle", c), cycle_count, entry.due);
          end
        end
      end
    end
  end

  initial begin
    int leftover;
    reset = 1'b1;
    in_data = '0;
    in_valid = '0;
    cfg_req = 1'b0;
    cfg_channel = '0;
    cfg_scale = '0;
    cfg_offset = '0;
    lfsr = 16'd24613;
    cycle_count = 0;
    timeout_limit = 100;
    for (int r = 0; r < num_rows; r++) begin
      timeout_limit += 2 * int'(stim_table[r].beats) + 20;
    end
    for (int c = 0; c < channels; c++) begin
      model_scale[c] = scale_one;
      model_offset[c] = '0;
    end
    repeat (16) @(posedge clk);
    reset <= 1'b0;

    for (int r = 0; r < num_rows; r++) begin
      if (stim_table[r].do_write) begin
        write_coeff(stim_table[r].channel, stim_table[r].scale, stim_table[r].offset);
      end
      repeat (3) @(posedge clk);
      stream_beats(int'(stim_table[r].beats), stim_table[r].alternate);
      repeat (lane_latency + 1) @(posedge clk);
    end

    @(negedge clk);
    leftover = 0;
    for (int c = 0; c < channels; c++) begin
      leftover += exp_q[c].size();
    end
    if (leftover != 0) begin
      stop_on_failure($sformatf("%0d expected beats never came out of the DUT", leftover));
    end else begin
      $display("All tests passed");
      $finish;
    end
  end

endmodule
